// ==== hdl/adder_pkg.sv ====
// adder lane parameters, operation codes and vector types
`default_nettype none

package adder_pkg;

	// datapath and storage sizes
	localparam int XLEN = 64;
	localparam int PRF_DEPTH = 64;
	localparam int ISSUE_DP = 4;

	// register value or operand
	typedef logic [XLEN-1:0] xdata_t;

	// physical register index
	typedef logic [$clog2(PRF_DEPTH)-1:0] preg_t;

	// issue buffer slot index
	typedef logic [$clog2(ISSUE_DP)-1:0] slot_t;

	// decoded add-type operation
	typedef logic [2:0] adder_op_t;

	localparam adder_op_t OP_LUI = 3'd0;
	localparam adder_op_t OP_AUIPC = 3'd1;
	localparam adder_op_t OP_ADDI = 3'd2;
	localparam adder_op_t OP_ADDIW = 3'd3;
	localparam adder_op_t OP_ADD = 3'd4;
	localparam adder_op_t OP_ADDW = 3'd5;
	localparam adder_op_t OP_SUB = 3'd6;
	localparam adder_op_t OP_SUBW = 3'd7;

endpackage

`default_nettype wire

// ==== hdl/adder_if.sv ====
// interfaces issue_buf_if, exeparam_if and regread_if
`timescale 1ns/1ps
`default_nettype none

interface issue_buf_if import adder_pkg::*; ();
	logic [ISSUE_DP-1:0] malloc;
	adder_op_t op [ISSUE_DP];
	xdata_t pc [ISSUE_DP];
	xdata_t imm [ISSUE_DP];
	preg_t rd [ISSUE_DP];
	preg_t rs1 [ISSUE_DP];
	preg_t rs2 [ISSUE_DP];
	logic pop;
	slot_t pop_index;

	modport buffer (output malloc, op, pc, imm, rd, rs1, rs2, input pop, pop_index);
	modport issue (input malloc, op, pc, imm, rd, rs1, rs2, output pop, pop_index);
endinterface

// no ready since the adder always accepts
interface exeparam_if import adder_pkg::*; ();
	logic valid;
	logic fun_sub;
	logic is32;
	preg_t rd;
	xdata_t op1;
	xdata_t op2;

	modport issue (output valid, fun_sub, is32, rd, op1, op2);
	modport execute (input valid, fun_sub, is32, rd, op1, op2);
endinterface

interface regread_if import adder_pkg::*; ();
	preg_t rs1 [ISSUE_DP];
	preg_t rs2 [ISSUE_DP];
	xdata_t rs1_data [ISSUE_DP];
	xdata_t rs2_data [ISSUE_DP];
	logic [ISSUE_DP-1:0] rs1_ready;
	logic [ISSUE_DP-1:0] rs2_ready;

	modport issue (output rs1, rs2, input rs1_data, rs2_data, rs1_ready, rs2_ready);
	modport regfile (input rs1, rs2, output rs1_data, rs2_data, rs1_ready, rs2_ready);
endinterface

`default_nettype wire

// ==== hdl/issue_buffer.sv ====
// issue buffer slots with lowest-free allocation and pop by index
`timescale 1ns/1ps
`default_nettype none

module issue_buffer import adder_pkg::*; (
	input logic CLK,
	input logic arst_n,

	input logic disp_valid,
	input adder_op_t disp_op,
	input xdata_t disp_pc,
	input xdata_t disp_imm,
	input preg_t disp_rd,
	input preg_t disp_rs1,
	input preg_t disp_rs2,
	output logic disp_ready,

	issue_buf_if.buffer ibuf
);

	logic free_found;
	slot_t free_idx;
	logic disp_fire;

	// lowest free slot
	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		for (int i = ISSUE_DP - 1; i >= 0; i--) begin
			if (!ibuf.malloc[i]) begin
				free_found = 1'b1;
				free_idx = slot_t'(i);
			end
		end
	end

	assign disp_ready = free_found;
	assign disp_fire = disp_valid & free_found;

	// a freed slot is only reused from the next cycle on
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ibuf.malloc <= '0;
		end else begin
			if (ibuf.pop) begin
				ibuf.malloc[ibuf.pop_index] <= 1'b0;
			end
			if (disp_fire) begin
				ibuf.malloc[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (disp_fire) begin
			ibuf.op[free_idx] <= disp_op;
			ibuf.pc[free_idx] <= disp_pc;
			ibuf.imm[free_idx] <= disp_imm;
			ibuf.rd[free_idx] <= disp_rd;
			ibuf.rs1[free_idx] <= disp_rs1;
			ibuf.rs2[free_idx] <= disp_rs2;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/adder_issue.sv ====
// adder issue stage with RAW check, operand select, lowest-index pick
// and the execute parameter register
`timescale 1ns/1ps
`default_nettype none

module adder_issue import adder_pkg::*; (
	input logic CLK,
	input logic arst_n,

	issue_buf_if.issue ibuf,
	regread_if.issue rread,
	exeparam_if.issue exe
);

	logic [ISSUE_DP-1:0] raw_ok;
	logic [ISSUE_DP-1:0] clear_raw;
	logic [ISSUE_DP-1:0] sub_sel;
	logic [ISSUE_DP-1:0] is32_sel;
	xdata_t op1_sel [ISSUE_DP];
	xdata_t op2_sel [ISSUE_DP];
	logic pick_any;
	slot_t pick_idx;

	// source indices of every slot go to the register file
	always_comb begin
		for (int i = 0; i < ISSUE_DP; i++) begin
			rread.rs1[i] = ibuf.rs1[i];
			rread.rs2[i] = ibuf.rs2[i];
		end
	end

	// per slot decode with register forms as default
	always_comb begin
		for (int i = 0; i < ISSUE_DP; i++) begin
			op1_sel[i] = rread.rs1_data[i];
			op2_sel[i] = rread.rs2_data[i];
			sub_sel[i] = 1'b0;
			is32_sel[i] = 1'b0;
			raw_ok[i] = rread.rs1_ready[i] & rread.rs2_ready[i];
			case (ibuf.op[i])
				OP_LUI: begin
					op1_sel[i] = '0;
					op2_sel[i] = ibuf.imm[i];
					raw_ok[i] = 1'b1;
				end
				OP_AUIPC: begin
					op1_sel[i] = ibuf.pc[i];
					op2_sel[i] = ibuf.imm[i];
					raw_ok[i] = 1'b1;
				end
				OP_ADDI: begin
					op2_sel[i] = ibuf.imm[i];
					raw_ok[i] = rread.rs1_ready[i];
				end
				OP_ADDIW: begin
					op2_sel[i] = ibuf.imm[i];
					raw_ok[i] = rread.rs1_ready[i];
					is32_sel[i] = 1'b1;
				end
				OP_ADD: begin
				end
				OP_ADDW: begin
					is32_sel[i] = 1'b1;
				end
				OP_SUB: begin
					sub_sel[i] = 1'b1;
				end
				OP_SUBW: begin
					sub_sel[i] = 1'b1;
					is32_sel[i] = 1'b1;
				end
			endcase
		end
	end

	assign clear_raw = ibuf.malloc & raw_ok;

	// lowest index wins
	always_comb begin
		pick_any = 1'b0;
		pick_idx = '0;
		for (int i = ISSUE_DP - 1; i >= 0; i--) begin
			if (clear_raw[i]) begin
				pick_any = 1'b1;
				pick_idx = slot_t'(i);
			end
		end
	end

	assign ibuf.pop = pick_any;
	assign ibuf.pop_index = pick_idx;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			exe.valid <= 1'b0;
		end else begin
			exe.valid <= pick_any;
		end
	end

	// parameters hold when nothing issues
	always_ff @(posedge CLK) begin
		if (pick_any) begin
			exe.fun_sub <= sub_sel[pick_idx];
			exe.is32 <= is32_sel[pick_idx];
			exe.rd <= ibuf.rd[pick_idx];
			exe.op1 <= op1_sel[pick_idx];
			exe.op2 <= op2_sel[pick_idx];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/adder_execute.sv ====
// adder execute stage with word sign extension and writeback register
`timescale 1ns/1ps
`default_nettype none

module adder_execute import adder_pkg::*; (
	input logic CLK,
	input logic arst_n,

	exeparam_if.execute exe,

	output logic wb_valid,
	output preg_t wb_rd,
	output xdata_t wb_data
);

	xdata_t sum;
	xdata_t result;

	assign sum = exe.fun_sub ? (exe.op1 - exe.op2) : (exe.op1 + exe.op2);

	// W forms keep the low word and extend its sign
	assign result = exe.is32 ? {{(XLEN - 32){sum[31]}}, sum[31:0]} : sum;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe.valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe.valid) begin
			wb_rd <= exe.rd;
			wb_data <= result;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/phy_regfile.sv ====
// physical register file with ready log, preload and writeback ports
`timescale 1ns/1ps
`default_nettype none

module phy_regfile import adder_pkg::*; (
	input logic CLK,
	input logic arst_n,

	regread_if.regfile rread,

	input logic disp_fire,
	input preg_t disp_rd,

	input logic init_we,
	input preg_t init_addr,
	input xdata_t init_data,

	input logic wb_valid,
	input preg_t wb_rd,
	input xdata_t wb_data
);

	xdata_t regs [PRF_DEPTH];
	logic [PRF_DEPTH-1:0] ready;

	// x0 reads zero and is never busy
	function automatic xdata_t read_val(preg_t addr);
		return (addr == '0) ? '0 : regs[addr];
	endfunction

	function automatic logic read_rdy(preg_t addr);
		return (addr == '0) | ready[addr];
	endfunction

	always_comb begin
		for (int i = 0; i < ISSUE_DP; i++) begin
			rread.rs1_data[i] = read_val(rread.rs1[i]);
			rread.rs2_data[i] = read_val(rread.rs2[i]);
			rread.rs1_ready[i] = read_rdy(rread.rs1[i]);
			rread.rs2_ready[i] = read_rdy(rread.rs2[i]);
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < PRF_DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (init_we) begin
				regs[init_addr] <= init_data;
			end
			if (wb_valid) begin
				regs[wb_rd] <= wb_data;
			end
		end
	end

	// busy from dispatch until written
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ready <= '1;
		end else begin
			if (disp_fire) begin
				ready[disp_rd] <= 1'b0;
			end
			if (init_we) begin
				ready[init_addr] <= 1'b1;
			end
			if (wb_valid) begin
				ready[wb_rd] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/adder_core.sv ====
// adder lane top with issue buffer, issue stage, execute and register file
`timescale 1ns/1ps
`default_nettype none

module adder_core import adder_pkg::*; (
	input logic CLK,
	input logic arst_n,

	input logic disp_valid,
	output logic disp_ready,
	input adder_op_t disp_op,
	input xdata_t disp_pc,
	input xdata_t disp_imm,
	input preg_t disp_rd,
	input preg_t disp_rs1,
	input preg_t disp_rs2,

	input logic init_we,
	input preg_t init_addr,
	input xdata_t init_data,

	output logic wb_valid,
	output preg_t wb_rd,
	output xdata_t wb_data
);

	logic disp_fire;

	issue_buf_if ibuf ();
	exeparam_if exe ();
	regread_if rread ();

	assign disp_fire = disp_valid & disp_ready;

	issue_buffer i_issue_buffer (
		.CLK(CLK),
		.arst_n(arst_n),
		.disp_valid(disp_valid),
		.disp_op(disp_op),
		.disp_pc(disp_pc),
		.disp_imm(disp_imm),
		.disp_rd(disp_rd),
		.disp_rs1(disp_rs1),
		.disp_rs2(disp_rs2),
		.disp_ready(disp_ready),
		.ibuf(ibuf.buffer)
	);

	adder_issue i_adder_issue (
		.CLK(CLK),
		.arst_n(arst_n),
		.ibuf(ibuf.issue),
		.rread(rread.issue),
		.exe(exe.issue)
	);

	adder_execute i_adder_execute (
		.CLK(CLK),
		.arst_n(arst_n),
		.exe(exe.execute),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	phy_regfile i_phy_regfile (
		.CLK(CLK),
		.arst_n(arst_n),
		.rread(rread.regfile),
		.disp_fire(disp_fire),
		.disp_rd(disp_rd),
		.init_we(init_we),
		.init_addr(init_addr),
		.init_data(init_data),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== test/tb_adder_core.sv ====
// adder lane testbench with xorshift stimulus, reference model
// and assertion checks on the writeback port
`timescale 1ns/1ps
`default_nettype none

module tb_adder_core import adder_pkg::*; ();

	localparam int MAX_CYCLES = 4000;

	logic CLK;
	logic arst_n;
	logic disp_valid;
	logic disp_ready;
	adder_op_t disp_op;
	xdata_t disp_pc;
	xdata_t disp_imm;
	preg_t disp_rd;
	preg_t disp_rs1;
	preg_t disp_rs2;
	logic init_we;
	preg_t init_addr;
	xdata_t init_data;
	logic wb_valid;
	preg_t wb_rd;
	xdata_t wb_data;

	// model state per physical register
	xdata_t model_reg [PRF_DEPTH];
	xdata_t exp_val [PRF_DEPTH];
	logic pending [PRF_DEPTH];
	logic lat_chk [PRF_DEPTH];
	int use_cnt [PRF_DEPTH];
	int acc_cyc [PRF_DEPTH];
	int seq_of [PRF_DEPTH];
	preg_t src1_of [PRF_DEPTH];
	preg_t src2_of [PRF_DEPTH];
	int n_pending;
	int seq_n;
	int cyc;
	logic lat_on;
	logic ooo_seen;
	logic [31:0] rng;
	string test_name;

	adder_core i_dut (.*);

	always #4 CLK = ~CLK;

	task automatic abort(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic mismatch(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
		$display("ERR %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic xdata_t rand64();
		xdata_t v;
		v[63:32] = rand32();
		v[31:0] = rand32();
		return v;
	endfunction

	// expected result from the operand, add/sub and word rules
	function automatic xdata_t model_result(input adder_op_t op, input xdata_t pc,
			input xdata_t imm, input xdata_t a, input xdata_t b);
		xdata_t x;
		xdata_t y;
		xdata_t s;
		x = (op == OP_LUI) ? '0 : ((op == OP_AUIPC) ? pc : a);
		y = (op inside {OP_LUI, OP_AUIPC, OP_ADDI, OP_ADDIW}) ? imm : b;
		s = (op inside {OP_SUB, OP_SUBW}) ? x - y : x + y;
		if (op inside {OP_ADDIW, OP_ADDW, OP_SUBW}) begin
			s = {{32{s[31]}}, s[31:0]};
		end
		return s;
	endfunction

	// register that is not in flight and read by nothing pending
	task automatic pick_free(input preg_t x1, input preg_t x2, output preg_t r);
		int start;
		int c;
		start = int'(rand32() % 32'd63);
		r = '0;
		for (int k = 0; k < 63; k++) begin
			c = (start + k) % 63 + 1;
			if (r == '0 && use_cnt[c] == 0 && preg_t'(c) != x1 && preg_t'(c) != x2) begin
				r = preg_t'(c);
			end
		end
		if (r == '0) begin
			abort("no free physical register left for the stimulus");
		end
	endtask

	task automatic preload(input preg_t addr, input xdata_t data);
		init_we = 1'b1;
		init_addr = addr;
		init_data = data;
		@(posedge CLK);
		#1;
		init_we = 1'b0;
	endtask

	task automatic dispatch(input adder_op_t op, input preg_t rd, input preg_t rs1,
			input preg_t rs2, input xdata_t imm);
		disp_valid = 1'b1;
		disp_op = op;
		disp_pc = rand64();
		disp_imm = imm;
		disp_rd = rd;
		disp_rs1 = rs1;
		disp_rs2 = rs2;
		do begin
			@(posedge CLK);
		end while (!disp_ready);
		#1;
		disp_valid = 1'b0;
	endtask

	task automatic wait_idle();
		do begin
			@(posedge CLK);
			#1;
		end while (n_pending != 0);
	endtask

	// model update and checks on the rising edge
	always @(posedge CLK) begin
		int lat;
		cyc++;
		if (cyc >= MAX_CYCLES) begin
			abort($sformatf("timeout after %0d cycles", cyc));
		end
		if (arst_n) begin
			if (wb_valid) begin
				assert (pending[wb_rd])
					else abort($sformatf("writeback to p%0d with nothing in flight", wb_rd));
				assert (wb_data == exp_val[wb_rd])
					else mismatch($sformatf("p%0d", wb_rd), exp_val[wb_rd], wb_data);
				if (lat_chk[wb_rd]) begin
					// wb_valid rises at the second edge and is seen one edge later
					lat = cyc - acc_cyc[wb_rd] - 1;
					assert (lat == 2) else mismatch("latency", 64'(2), 64'(lat));
				end
				for (int r = 1; r < PRF_DEPTH; r++) begin
					if (pending[r] && seq_of[r] < seq_of[wb_rd]) begin
						ooo_seen = 1'b1;
					end
				end
				pending[wb_rd] = 1'b0;
				lat_chk[wb_rd] = 1'b0;
				n_pending--;
				use_cnt[wb_rd]--;
				if (src1_of[wb_rd] != '0) begin
					use_cnt[src1_of[wb_rd]]--;
				end
				if (src2_of[wb_rd] != '0) begin
					use_cnt[src2_of[wb_rd]]--;
				end
			end
			if (disp_valid && disp_ready) begin
				exp_val[disp_rd] = model_result(disp_op, disp_pc, disp_imm,
					model_reg[disp_rs1], model_reg[disp_rs2]);
				model_reg[disp_rd] = exp_val[disp_rd];
				pending[disp_rd] = 1'b1;
				lat_chk[disp_rd] = lat_on;
				acc_cyc[disp_rd] = cyc;
				seq_of[disp_rd] = seq_n;
				seq_n++;
				n_pending++;
				src1_of[disp_rd] = disp_rs1;
				src2_of[disp_rd] = disp_rs2;
				use_cnt[disp_rd]++;
				if (disp_rs1 != '0) begin
					use_cnt[disp_rs1]++;
				end
				if (disp_rs2 != '0) begin
					use_cnt[disp_rs2]++;
				end
			end
			if (init_we && init_addr != '0) begin
				model_reg[init_addr] = init_data;
			end
		end
	end

	initial begin
		preg_t a;
		preg_t b;
		preg_t d;
		preg_t prev;
		logic [31:0] rnd;
		adder_op_t dep_ops [4];
		CLK = 1'b0;
		arst_n = 1'b0;
		disp_valid = 1'b0;
		disp_op = OP_ADD;
		disp_pc = '0;
		disp_imm = '0;
		disp_rd = '0;
		disp_rs1 = '0;
		disp_rs2 = '0;
		init_we = 1'b0;
		init_addr = '0;
		init_data = '0;
		rng = 32'h649cdbf2;
		n_pending = 0;
		seq_n = 0;
		cyc = 0;
		lat_on = 1'b0;
		ooo_seen = 1'b0;
		dep_ops = '{OP_ADD, OP_ADDI, OP_SUB, OP_ADDW};
		for (int r = 0; r < PRF_DEPTH; r++) begin
			model_reg[r] = '0;
			exp_val[r] = '0;
			pending[r] = 1'b0;
			lat_chk[r] = 1'b0;
			use_cnt[r] = 0;
		end
		repeat (16) @(posedge CLK);
		#1;
		arst_n = 1'b1;
		@(posedge CLK);
		#1;

		test_name = "reset";
		assert (!wb_valid) else mismatch("wb_valid", 64'(0), 64'(wb_valid));
		assert (disp_ready) else mismatch("disp_ready", 64'(1), 64'(disp_ready));

		// all eight ops on preloaded random sources
		test_name = "arith";
		for (int k = 0; k < 24; k++) begin
			pick_free('0, '0, a);
			preload(a, rand64());
			pick_free(a, '0, b);
			preload(b, rand64());
			pick_free(a, b, d);
			rnd = rand32();
			dispatch((k < 8) ? adder_op_t'(k) : rnd[2:0], d, a, b, rand64());
		end
		// word overflow across bit 31 and negative results
		pick_free('0, '0, a);
		preload(a, 64'h0000_0000_7fff_fff0);
		pick_free(a, '0, d);
		dispatch(OP_ADDIW, d, a, '0, 64'h20);
		pick_free(a, '0, b);
		preload(b, 64'd5);
		pick_free(a, b, d);
		dispatch(OP_SUB, d, b, a, '0);
		pick_free(a, b, d);
		dispatch(OP_ADDW, d, a, a, '0);
		wait_idle();

		test_name = "latency";
		pick_free('0, '0, a);
		preload(a, rand64());
		pick_free(a, '0, b);
		preload(b, rand64());
		pick_free(a, b, d);
		lat_on = 1'b1;
		dispatch(OP_SUBW, d, a, b, rand64());
		lat_on = 1'b0;
		wait_idle();

		// dependent chain then independent ops that may pass it
		test_name = "raw";
		ooo_seen = 1'b0;
		pick_free('0, '0, a);
		preload(a, rand64());
		prev = a;
		for (int k = 0; k < 4; k++) begin
			pick_free(prev, a, d);
			dispatch((k[0]) ? OP_SUBW : OP_ADD, d, prev, a, '0);
			prev = d;
		end
		pick_free('0, '0, d);
		dispatch(OP_LUI, d, '0, '0, rand64());
		pick_free('0, '0, d);
		dispatch(OP_AUIPC, d, '0, '0, rand64());
		pick_free(a, '0, d);
		dispatch(OP_ADDI, d, a, '0, rand64());
		wait_idle();
		assert (ooo_seen) else abort("no independent instruction wrote back ahead of a blocked one");

		// long chain keeps the last source busy while four dependents fill the slots
		test_name = "full";
		pick_free('0, '0, a);
		preload(a, rand64());
		prev = a;
		for (int k = 0; k < 8; k++) begin
			pick_free(prev, '0, d);
			dispatch(OP_ADDI, d, prev, '0, rand64());
			prev = d;
		end
		for (int k = 0; k < 4; k++) begin
			pick_free(prev, '0, d);
			dispatch(dep_ops[k], d, prev, prev, rand64());
		end
		if (pending[prev]) begin
			assert (!disp_ready) else abort("disp_ready high with all four slots blocked");
		end
		wait_idle();

		test_name = "zero";
		pick_free('0, '0, d);
		lat_on = 1'b1;
		dispatch(OP_ADD, d, '0, '0, rand64());
		lat_on = 1'b0;
		pick_free('0, '0, d);
		dispatch(OP_ADDI, d, '0, '0, rand64());
		pick_free('0, '0, a);
		preload(a, rand64());
		pick_free(a, '0, d);
		dispatch(OP_SUBW, d, '0, a, '0);
		wait_idle();

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== adder_core.f ====
hdl/adder_pkg.sv
hdl/adder_if.sv
hdl/issue_buffer.sv
hdl/adder_issue.sv
hdl/adder_execute.sv
hdl/phy_regfile.sv
hdl/adder_core.sv
test/tb_adder_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the adder lane testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_adder_core \
	-f adder_core.f \
	-o tb_adder_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_adder_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
	exit 0
fi
echo "pass line missing from $LOG"
exit 1
